/* rtl/island_defs.svh */
////////////////////////////////////////////////////////////////////////////
// Widths and address map of the security island shell.
// Windows are base inclusive and end exclusive.
// ISL_NUM_REQ must stay a power of two for the requester index type.
////////////////////////////////////////////////////////////////////////////

`ifndef ISL_DEFS_SVH
`define ISL_DEFS_SVH

// Bus widths
`define ISL_ADDR_W      32
`define ISL_DATA_W      32

// Requesters on the router and synchronizer depth
`define ISL_NUM_REQ     4
`define ISL_SYNC_STAGES 3

// Address windows
`define ISL_HOST_BASE   32'h0001_0000
`define ISL_HOST_END    32'hA000_0000
`define ISL_CLS_BASE    32'hA100_0000
`define ISL_CLS_END     32'hB000_0000

`endif

/* rtl/island_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Vector types shared by the island RTL and its testbench.
// Widths come from the defines header.
////////////////////////////////////////////////////////////////////////////

`include "island_defs.svh"

package island_pkg;

   // Bus address and write data
   typedef logic [`ISL_ADDR_W-1:0] addr_t;
   typedef logic [`ISL_DATA_W-1:0] data_t;

   // One bit per requester
   typedef logic [`ISL_NUM_REQ-1:0] req_vec_t;

   // Requester number
   typedef logic [$clog2(`ISL_NUM_REQ)-1:0] req_idx_t;

endpackage

/* rtl/sync_chain.sv */
////////////////////////////////////////////////////////////////////////////
// Reset-to-zero flop chain for a slow asynchronous level.
// STAGES must be at least 2. Pulses shorter than one clock may be lost.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_chain #(
   parameter int unsigned STAGES = 3
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic async_i,
   output logic sync_o
);

   logic [STAGES-1:0] chain_q;

   // First stage may go metastable, later stages settle it
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         chain_q <= '0;
      end else begin
         chain_q <= {chain_q[STAGES-2:0], async_i};
      end
   end

   assign sync_o = chain_q[STAGES-1];

endmodule

/* rtl/addr_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// Maps an address to the host window, the cluster window or a miss.
// Purely combinational. The gap between the windows is a miss.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "island_defs.svh"

module addr_decoder
   import island_pkg::*;
(
   input  addr_t addr_i,
   output logic  hit_host_o,
   output logic  hit_cls_o,
   output logic  miss_o
);

   logic in_host;
   logic in_cls;

   // Base inclusive, end exclusive
   assign in_host = (addr_i >= addr_t'(`ISL_HOST_BASE)) &&
                    (addr_i <  addr_t'(`ISL_HOST_END));
   assign in_cls  = (addr_i >= addr_t'(`ISL_CLS_BASE)) &&
                    (addr_i <  addr_t'(`ISL_CLS_END));

   // Windows do not overlap, so at most one hit
   assign hit_host_o = in_host;
   assign hit_cls_o  = in_cls;
   assign miss_o     = !in_host && !in_cls;

endmodule

/* rtl/req_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter over the held requests.
// gnt_idx_o and gnt_valid_o are this cycle's pick, gnt_o is registered.
// The requester granted at the last edge is masked, its req is still up.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "island_defs.svh"

module req_arbiter
   import island_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  req_vec_t req_i,
   output req_vec_t gnt_o,
   output req_idx_t gnt_idx_o,
   output logic     gnt_valid_o
);

   req_idx_t last_q;
   req_vec_t gnt_q;
   req_vec_t eligible;
   req_idx_t pick_idx;
   logic     pick_valid;

   assign eligible = req_i & ~gnt_q;

   // First eligible requester counting upward after the last winner
   always_comb begin
      req_idx_t cand;
      pick_idx   = last_q;
      pick_valid = 1'b0;
      for (int i = 1; i <= `ISL_NUM_REQ; i++) begin
         cand = req_idx_t'((int'(last_q) + i) % `ISL_NUM_REQ);
         if (!pick_valid && eligible[cand]) begin
            pick_idx   = cand;
            pick_valid = 1'b1;
         end
      end
   end

   // Last winner resets to the top so the search starts at 0
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_q <= req_idx_t'(`ISL_NUM_REQ - 1);
         gnt_q  <= '0;
      end else begin
         gnt_q <= '0;
         if (pick_valid) begin
            last_q <= pick_idx;
            gnt_q  <= req_vec_t'(1) << pick_idx;
         end
      end
   end

   assign gnt_o       = gnt_q;
   assign gnt_idx_o   = pick_idx;
   assign gnt_valid_o = pick_valid;

endmodule

/* rtl/xbar_router.sv */
////////////////////////////////////////////////////////////////////////////
// Four requesters onto the host and cluster targets.
// Targets always accept, there is no response path.
// Strobes and payload are registered and line up with gnt_o.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "island_defs.svh"

module xbar_router
   import island_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  req_vec_t                  req_i,
   input  addr_t [`ISL_NUM_REQ-1:0]  addr_i,
   input  data_t [`ISL_NUM_REQ-1:0]  wdata_i,
   output req_vec_t                  gnt_o,
   output logic                      host_req_o,
   output logic                      cls_req_o,
   output logic                      dec_err_o,
   output addr_t                     out_addr_o,
   output data_t                     out_wdata_o,
   output req_idx_t                  out_src_o
);

   req_idx_t pick_idx;
   logic     pick_valid;
   addr_t    pick_addr;
   data_t    pick_wdata;
   logic     hit_host;
   logic     hit_cls;
   logic     miss;

   req_arbiter u_arbiter (
      .clk_i       ( clk_i      ),
      .rst_n_i     ( rst_n_i    ),
      .req_i       ( req_i      ),
      .gnt_o       ( gnt_o      ),
      .gnt_idx_o   ( pick_idx   ),
      .gnt_valid_o ( pick_valid )
   );

   // Winner's request, selected before the grant edge
   assign pick_addr  = addr_i[pick_idx];
   assign pick_wdata = wdata_i[pick_idx];

   addr_decoder u_decoder (
      .addr_i     ( pick_addr ),
      .hit_host_o ( hit_host  ),
      .hit_cls_o  ( hit_cls   ),
      .miss_o     ( miss      )
   );

   ////////////////////////////////////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         host_req_o <= 1'b0;
         cls_req_o  <= 1'b0;
         dec_err_o  <= 1'b0;
      end else begin
         host_req_o <= pick_valid & hit_host;
         cls_req_o  <= pick_valid & hit_cls;
         dec_err_o  <= pick_valid & miss;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pick_valid) begin
         out_addr_o  <= pick_addr;
         out_wdata_o <= pick_wdata;
         out_src_o   <= pick_idx;
      end
   end

endmodule

/* rtl/security_island.sv */
////////////////////////////////////////////////////////////////////////////
// Integration shell of the security island.
// Boot fetch enable and interrupt are brought in through synchronizers.
// Router strobes are single-cycle, targets never stall.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "island_defs.svh"

module security_island
   import island_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      fetch_en_i,
   input  logic                      irq_i,
   output logic                      fetch_en_sync_o,
   output logic                      irq_sync_o,
   // Requester side
   input  req_vec_t                  req_i,
   input  addr_t [`ISL_NUM_REQ-1:0]  addr_i,
   input  data_t [`ISL_NUM_REQ-1:0]  wdata_i,
   output req_vec_t                  gnt_o,
   // Target side
   output logic                      host_req_o,
   output logic                      cls_req_o,
   output logic                      dec_err_o,
   output addr_t                     out_addr_o,
   output data_t                     out_wdata_o,
   output req_idx_t                  out_src_o
);

   ////////////////////////////////////////////////////////////////////////
   // Synchronizers
   ////////////////////////////////////////////////////////////////////////

   sync_chain #(
      .STAGES ( `ISL_SYNC_STAGES )
   ) u_fetch_en_sync (
      .clk_i   ( clk_i           ),
      .rst_n_i ( rst_n_i         ),
      .async_i ( fetch_en_i      ),
      .sync_o  ( fetch_en_sync_o )
   );

   sync_chain #(
      .STAGES ( `ISL_SYNC_STAGES )
   ) u_irq_sync (
      .clk_i   ( clk_i      ),
      .rst_n_i ( rst_n_i    ),
      .async_i ( irq_i      ),
      .sync_o  ( irq_sync_o )
   );

   ////////////////////////////////////////////////////////////////////////
   // Router
   ////////////////////////////////////////////////////////////////////////

   xbar_router u_router (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .req_i       ( req_i       ),
      .addr_i      ( addr_i      ),
      .wdata_i     ( wdata_i     ),
      .gnt_o       ( gnt_o       ),
      .host_req_o  ( host_req_o  ),
      .cls_req_o   ( cls_req_o   ),
      .dec_err_o   ( dec_err_o   ),
      .out_addr_o  ( out_addr_o  ),
      .out_wdata_o ( out_wdata_o ),
      .out_src_o   ( out_src_o   )
   );

endmodule

/* sim/security_island_properties.sv */
////////////////////////////////////////////////////////////////////////////
// Grant and routing properties, bound into every xbar_router.
// Checks hold only outside reset.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module security_island_properties
   import island_pkg::*;
(
   input logic     clk_i,
   input logic     rst_n_i,
   input req_vec_t req_i,
   input req_vec_t gnt_o,
   input logic     host_req_o,
   input logic     cls_req_o,
   input logic     dec_err_o
);

   a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_o)) else $error("grant is not one-hot");

   // One strobe per grant, never two
   a_one_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({host_req_o, cls_req_o, dec_err_o}) &&
      ((gnt_o != '0) == (host_req_o | cls_req_o | dec_err_o)))
      else $error("target strobes do not match the grant");

   a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (gnt_o & ~$past(req_i)) == '0) else $error("grant without request");

   a_no_repeat : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (gnt_o & $past(gnt_o)) == '0) else $error("requester granted twice in a row");

endmodule

bind xbar_router security_island_properties u_props (.*);

/* sim/security_island_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the security island shell.
// A reference model predicts the next grant one cycle ahead and is
// checked at the falling edge. Inputs change only at the rising edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "island_defs.svh"

module security_island_tb
   import island_pkg::*;
;
   localparam int T_RESET = 20;
   localparam int T_SYNC  = 20;
   localparam int T_LONE  = 80;
   localparam int T_ALL   = 20;
   localparam int T_RAND  = 2400;
   localparam int CYCLE_LIMIT = 2 * (T_RESET + T_SYNC + T_LONE + T_ALL + T_RAND);
   localparam int N_RAND  = 200;

   logic clk_i = 1'b0;
   logic rst_n_i;
   logic fetch_en;
   logic irq;
   logic fetch_en_sync, irq_sync;
   req_vec_t req;
   addr_t [`ISL_NUM_REQ-1:0] addr;
   data_t [`ISL_NUM_REQ-1:0] wdata;
   req_vec_t gnt;
   logic host_req, cls_req, dec_err;
   addr_t out_addr;
   data_t out_wdata;
   req_idx_t out_src;

   // Requester queues, filled by the sequencer and drained by the driver
   addr_t pend_addr [`ISL_NUM_REQ][$];
   data_t pend_data [`ISL_NUM_REQ][$];
   int    pend_gap  [`ISL_NUM_REQ][$];
   int    wait_cnt  [`ISL_NUM_REQ];
   req_vec_t seen_gnt = '0;
   int n_checks = 0, n_errors = 0, n_tests = 0;
   int n_issued = 0, n_granted = 0, n_grants = 0;
   int cyc = 0;
   logic [31:0] rng = 32'hacb0;
   // Reference model state
   int model_last;
   logic exp_valid = 1'b0;
   req_idx_t exp_src;
   addr_t exp_addr;
   data_t exp_data;
   logic [2:0] exp_strobe;

   security_island u_dut (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .fetch_en_i (fetch_en), .irq_i (irq),
      .fetch_en_sync_o (fetch_en_sync), .irq_sync_o (irq_sync),
      .req_i (req), .addr_i (addr), .wdata_i (wdata), .gnt_o (gnt),
      .host_req_o (host_req), .cls_req_o (cls_req), .dec_err_o (dec_err),
      .out_addr_o (out_addr), .out_wdata_o (out_wdata), .out_src_o (out_src)
   );

   initial begin
      forever #5 clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////////////////
   // Reference functions
   ////////////////////////////////////////////////////////////////////////

   // 0 host, 1 cluster, 2 decode error
   function automatic int ref_target(addr_t a);
      if (a >= addr_t'(`ISL_HOST_BASE) && a < addr_t'(`ISL_HOST_END)) return 0;
      if (a >= addr_t'(`ISL_CLS_BASE) && a < addr_t'(`ISL_CLS_END)) return 1;
      return 2;
   endfunction

   function automatic logic [2:0] strobe_of(int target);
      return (target == 0) ? 3'b100 : (target == 1) ? 3'b010 : 3'b001;
   endfunction

   // Returns -1 when nobody is eligible
   function automatic int ref_next_winner(req_vec_t elig, int last);
      int c;
      for (int i = 1; i <= `ISL_NUM_REQ; i++) begin
         c = (last + i) % `ISL_NUM_REQ;
         if (elig[c]) return c;
      end
      return -1;
   endfunction

   function automatic logic [31:0] rand_next();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////

   task automatic check_addr(string name, addr_t got, addr_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_data(string name, data_t got, data_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_idx(string name, req_idx_t got, req_idx_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_vec(string name, req_vec_t got, req_vec_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Triple is {host, cluster, decode error}
   task automatic check_strobe(string name, logic [2:0] got, logic [2:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(string what, int got, int exp);
      n_checks++;
      if (got != exp) begin
         n_errors++;
         $display("Wrong count at %0t: %s was %0d but %0d were expected",
                  $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Compare process and requester driver
   ////////////////////////////////////////////////////////////////////////

   always @(negedge clk_i) begin
      req_vec_t mask;
      int w;
      seen_gnt = gnt;
      if (!rst_n_i) begin
         model_last = `ISL_NUM_REQ - 1;
         exp_valid  = 1'b0;
      end else begin
         if (exp_valid) begin
            check_vec("gnt_o", gnt, req_vec_t'(1) << exp_src);
            check_idx("out_src_o", out_src, exp_src);
            check_addr("out_addr_o", out_addr, exp_addr);
            check_data("out_wdata_o", out_wdata, exp_data);
            check_strobe("target strobes", {host_req, cls_req, dec_err}, exp_strobe);
            n_grants++;
         end else begin
            check_vec("gnt_o", gnt, '0);
            check_strobe("target strobes", {host_req, cls_req, dec_err}, 3'b000);
         end
         // Winner at the coming edge, last grant still masked
         mask = exp_valid ? (req_vec_t'(1) << exp_src) : '0;
         w = ref_next_winner(req & ~mask, model_last);
         exp_valid = (w >= 0);
         if (exp_valid) begin
            exp_src    = req_idx_t'(w);
            exp_addr   = addr[w];
            exp_data   = wdata[w];
            exp_strobe = strobe_of(ref_target(addr[w]));
            model_last = w;
         end
      end
   end

   always @(posedge clk_i) begin
      if (rst_n_i) begin
         for (int n = 0; n < `ISL_NUM_REQ; n++) begin
            if (req[n]) begin
               if (seen_gnt[n]) begin
                  req[n] <= 1'b0;
                  n_granted++;
               end
            end else if (pend_addr[n].size() > 0) begin
               if (wait_cnt[n] < pend_gap[n][0]) begin
                  wait_cnt[n]++;
               end else begin
                  void'(pend_gap[n].pop_front());
                  addr[n]     <= pend_addr[n].pop_front();
                  wdata[n]    <= pend_data[n].pop_front();
                  req[n]      <= 1'b1;
                  wait_cnt[n] = 0;
               end
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////////////////

   task automatic push_req(int n, addr_t a, data_t d, int gap);
      pend_addr[n].push_back(a);
      pend_data[n].push_back(d);
      pend_gap[n].push_back(gap);
      n_issued++;
   endtask

   task automatic wait_idle();
      int busy;
      busy = 1;
      while (busy != 0) begin
         @(negedge clk_i);
         busy = (req != '0) || (n_granted != n_issued) ? 1 : 0;
         for (int n = 0; n < `ISL_NUM_REQ; n++) begin
            if (pend_addr[n].size() > 0) busy = 1;
         end
      end
      @(negedge clk_i);
   endtask

   task automatic end_test(string name, int err_before);
      n_tests++;
      $display("test %-10s %s (%0d errors)", name,
               (n_errors == err_before) ? "passed" : "failed", n_errors - err_before);
   endtask

   task automatic sync_step(logic fv, logic iv);
      logic old_f, old_i;
      old_f = fetch_en;
      old_i = irq;
      @(posedge clk_i);
      fetch_en <= fv;
      irq      <= iv;
      for (int i = 1; i <= `ISL_SYNC_STAGES + 1; i++) begin
         @(negedge clk_i);
         check_bit("fetch_en_sync_o", fetch_en_sync, (i <= `ISL_SYNC_STAGES) ? old_f : fv);
         check_bit("irq_sync_o", irq_sync, (i <= `ISL_SYNC_STAGES) ? old_i : iv);
      end
   endtask

   addr_t edges [10] = '{32'h0000_0000, 32'h0000_FFFF, 32'h0001_0000, 32'h9FFF_FFFF,
                         32'hA000_0000, 32'hA0FF_FFFF, 32'hA100_0000, 32'hAFFF_FFFF,
                         32'hB000_0000, 32'hFFFF_FFFF};

   initial begin
      int e0, g0;
      addr_t a;
      rst_n_i  = 1'b0;
      fetch_en = 1'b0;
      irq      = 1'b0;
      req      = '0;
      addr     = '0;
      wdata    = '0;
      for (int n = 0; n < `ISL_NUM_REQ; n++) wait_cnt[n] = 0;

      // Reset values, during reset and one cycle after
      e0 = n_errors;
      repeat (5) @(negedge clk_i);
      check_vec("gnt_o", gnt, '0);
      check_strobe("target strobes", {host_req, cls_req, dec_err}, 3'b000);
      check_bit("fetch_en_sync_o", fetch_en_sync, 1'b0);
      check_bit("irq_sync_o", irq_sync, 1'b0);
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_vec("gnt_o", gnt, '0);
      check_bit("fetch_en_sync_o", fetch_en_sync, 1'b0);
      check_bit("irq_sync_o", irq_sync, 1'b0);
      end_test("reset", e0);

      e0 = n_errors;
      sync_step(1'b1, 1'b0);
      sync_step(1'b1, 1'b1);
      sync_step(1'b0, 1'b0);
      end_test("sync", e0);

      // Lone requests over the window edges
      e0 = n_errors;
      g0 = n_grants;
      for (int i = 0; i < 10; i++) begin
         push_req(i % `ISL_NUM_REQ, edges[i], ~edges[i], 0);
         wait_idle();
      end
      check_count("lone grants", n_grants - g0, 10);
      end_test("lone", e0);

      // All four held together
      e0 = n_errors;
      g0 = n_grants;
      for (int n = 0; n < `ISL_NUM_REQ; n++) begin
         push_req(n, edges[n * 2 + 1], data_t'(32'h5A00_0000 + n), 0);
      end
      wait_idle();
      check_count("contended grants", n_grants - g0, `ISL_NUM_REQ);
      end_test("contend", e0);

      e0 = n_errors;
      g0 = n_grants;
      for (int i = 0; i < N_RAND; i++) begin
         a = (rand_next() % 4 == 0) ? edges[rand_next() % 10] : rand_next();
         push_req(int'(rand_next() % `ISL_NUM_REQ), a, rand_next(), int'(rand_next() % 8));
      end
      wait_idle();
      check_count("random grants", n_grants - g0, N_RAND);
      end_test("random", e0);

      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* security_island.f */
+incdir+rtl
rtl/island_pkg.sv
rtl/sync_chain.sv
rtl/addr_decoder.sv
rtl/req_arbiter.sv
rtl/xbar_router.sv
rtl/security_island.sv
sim/security_island_properties.sv
sim/security_island_tb.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := security_island_tb
FLIST := security_island.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
